//--- hdl/matrix_pkg.sv
/*
 * Shared definitions for the LED-matrix command front end: panel geometry,
 * vector types and the command character codes.
 */
package matrix_pkg;

    localparam int ROW_BITS          = 5;
    localparam int COL_BITS          = 6;
    localparam int BRIGHTNESS_LEVELS = 6;
    // row, column, then byte select
    localparam int RAM_ADDR_BITS     = ROW_BITS + COL_BITS + 1;

    typedef logic [7:0]                   byte_t;
    typedef logic [ROW_BITS-1:0]          row_t;
    typedef logic [COL_BITS-1:0]          col_t;
    typedef logic [RAM_ADDR_BITS-1:0]     ram_addr_t;
    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;
    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0]                   rgb_t;

    typedef enum logic [7:0] {
        CMD_PLANE_0    = 8'h30, CMD_PLANE_1   = 8'h31, CMD_PLANE_2  = 8'h32,
        CMD_PLANE_3    = 8'h33, CMD_PLANE_4   = 8'h34, CMD_PLANE_5  = 8'h35,
        CMD_PLANE_6    = 8'h36, CMD_PLANE_ALL = 8'h39,
        CMD_BLUE_ON    = 8'h42, CMD_GREEN_ON  = 8'h47, CMD_PIXEL    = 8'h50,
        CMD_RED_ON     = 8'h52, CMD_BRIGHTNESS = 8'h54, CMD_BLANK   = 8'h5a,
        CMD_BLUE_OFF   = 8'h62, CMD_GREEN_OFF = 8'h67, CMD_RED_OFF  = 8'h72
    } cmd_char_t;

endpackage

//--- hdl/command_decoder.sv
/*
 * Command decoder: registers each strobed byte and routes it to the
 * config registers, the brightness load, the blank engine or the pixel engine.
 */
`timescale 1ns/1ps

module command_decoder (
    input  logic              clk_in,
    input  logic              reset,
    input  matrix_pkg::byte_t data_rx,
    input  logic              data_ready_n,
    input  logic              blank_done,
    input  logic              pixel_done,
    output matrix_pkg::byte_t cmd_byte,
    output logic              cmd_byte_valid,
    output logic              brightness_load,
    output logic              blank_start,
    output logic              pixel_byte_valid,
    output logic              busy,
    output logic              ready_for_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BRIGHTNESS,
        ST_BLANK,
        ST_PIXEL
    } state_t;

    state_t            state;
    matrix_pkg::byte_t byte_q;
    logic              strobe_q;

    always_ff @(posedge clk_in) begin
        if (!data_ready_n) begin
            byte_q <= data_rx;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            strobe_q <= 1'b0;
            state    <= ST_IDLE;
        end else begin
            // bytes arriving during a blank sweep are dropped
            strobe_q <= !data_ready_n && ready_for_data;
            case (state)
                ST_IDLE: begin
                    if (strobe_q) begin
                        case (byte_q)
                            matrix_pkg::CMD_BRIGHTNESS: state <= ST_BRIGHTNESS;
                            matrix_pkg::CMD_BLANK:      state <= ST_BLANK;
                            matrix_pkg::CMD_PIXEL:      state <= ST_PIXEL;
                            default:                    state <= ST_IDLE;
                        endcase
                    end
                end
                ST_BRIGHTNESS: begin
                    if (strobe_q) begin
                        state <= ST_IDLE;
                    end
                end
                ST_BLANK: begin
                    if (blank_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_PIXEL: begin
                    if (pixel_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign cmd_byte         = byte_q;
    assign cmd_byte_valid   = strobe_q && (state == ST_IDLE);
    assign brightness_load  = strobe_q && (state == ST_BRIGHTNESS);
    assign pixel_byte_valid = strobe_q && (state == ST_PIXEL);
    assign blank_start      = cmd_byte_valid && (byte_q == matrix_pkg::CMD_BLANK);

    assign busy           = (state != ST_IDLE);
    assign ready_for_data = (state != ST_BLANK);

endmodule

//--- hdl/display_config_regs.sv
/*
 * Display configuration registers: colour-channel enables and
 * brightness bit-plane enables, updated from decoded command bytes.
 */
`timescale 1ns/1ps

module display_config_regs (
    input  logic                    clk_in,
    input  logic                    reset,
    input  matrix_pkg::byte_t       cmd_byte,
    input  logic                    cmd_byte_valid,
    input  logic                    brightness_load,
    output matrix_pkg::rgb_t        rgb_enable,
    output matrix_pkg::brightness_t brightness_enable
);

    matrix_pkg::brightness_t plane_toggle;

    // digit n flips plane BRIGHTNESS_LEVELS - n
    always_comb begin
        plane_toggle = '0;
        for (int n = 1; n <= matrix_pkg::BRIGHTNESS_LEVELS; n++) begin
            if (cmd_byte == matrix_pkg::byte_t'(matrix_pkg::CMD_PLANE_0 + n)) begin
                plane_toggle[matrix_pkg::BRIGHTNESS_LEVELS - n] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else if (brightness_load) begin
            brightness_enable <= cmd_byte[matrix_pkg::BRIGHTNESS_LEVELS-1:0];
        end else if (cmd_byte_valid) begin
            case (cmd_byte)
                matrix_pkg::CMD_RED_ON:    rgb_enable[0] <= 1'b1;
                matrix_pkg::CMD_RED_OFF:   rgb_enable[0] <= 1'b0;
                matrix_pkg::CMD_GREEN_ON:  rgb_enable[1] <= 1'b1;
                matrix_pkg::CMD_GREEN_OFF: rgb_enable[1] <= 1'b0;
                matrix_pkg::CMD_BLUE_ON:   rgb_enable[2] <= 1'b1;
                matrix_pkg::CMD_BLUE_OFF:  rgb_enable[2] <= 1'b0;
                matrix_pkg::CMD_PLANE_1,
                matrix_pkg::CMD_PLANE_2,
                matrix_pkg::CMD_PLANE_3,
                matrix_pkg::CMD_PLANE_4,
                matrix_pkg::CMD_PLANE_5,
                matrix_pkg::CMD_PLANE_6: begin
                    brightness_enable <= brightness_enable ^ plane_toggle;
                end
                matrix_pkg::CMD_PLANE_0:   brightness_enable <= '0;
                matrix_pkg::CMD_PLANE_ALL: brightness_enable <= '1;
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/blank_engine.sv
/*
 * Blank engine: sweeps the whole frame RAM once, writing zero to every byte.
 */
`timescale 1ns/1ps

module blank_engine (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  blank_start,
    output logic                  wr_req,
    output matrix_pkg::ram_addr_t wr_addr,
    output matrix_pkg::byte_t     wr_data,
    output logic                  blank_done
);

    logic                  active;
    matrix_pkg::ram_addr_t addr;

    // addr wraps back to zero after the last write
    always_ff @(posedge clk_in) begin
        if (reset) begin
            active <= 1'b0;
            addr   <= '0;
        end else if (blank_start) begin
            active <= 1'b1;
            addr   <= '0;
        end else if (active) begin
            addr <= addr + 1'b1;
            if (addr == '1) begin
                active <= 1'b0;
            end
        end
    end

    assign wr_req     = active;
    assign wr_addr    = addr;
    assign wr_data    = '0;
    assign blank_done = active && (addr == '1);

endmodule

//--- hdl/pixel_write_engine.sv
/*
 * Pixel write engine: takes row, column and two data bytes, then writes
 * the pixel's two bytes into the frame RAM.
 */
`timescale 1ns/1ps

module pixel_write_engine (
    input  logic                  clk_in,
    input  logic                  reset,
    input  matrix_pkg::byte_t     cmd_byte,
    input  logic                  pixel_byte_valid,
    output logic                  wr_req,
    output matrix_pkg::ram_addr_t wr_addr,
    output matrix_pkg::byte_t     wr_data,
    output logic                  pixel_done
);

    logic [1:0]       byte_count;
    matrix_pkg::row_t row;
    matrix_pkg::col_t col;

    always_ff @(posedge clk_in) begin
        if (pixel_byte_valid) begin
            case (byte_count)
                2'd0:    row <= cmd_byte[matrix_pkg::ROW_BITS-1:0];
                2'd1:    col <= cmd_byte[matrix_pkg::COL_BITS-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            byte_count <= '0;
            wr_req     <= 1'b0;
            wr_addr    <= '0;
            wr_data    <= '0;
            pixel_done <= 1'b0;
        end else begin
            // outputs sit at zero between writes
            wr_req     <= 1'b0;
            wr_addr    <= '0;
            wr_data    <= '0;
            pixel_done <= 1'b0;
            if (pixel_byte_valid) begin
                byte_count <= byte_count + 1'b1;
                case (byte_count)
                    2'd2: begin
                        // first data byte goes to the odd address
                        wr_req  <= 1'b1;
                        wr_addr <= {row, col, 1'b1};
                        wr_data <= cmd_byte;
                    end
                    2'd3: begin
                        wr_req     <= 1'b1;
                        wr_addr    <= {row, col, 1'b0};
                        wr_data    <= cmd_byte;
                        pixel_done <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hdl/ram_write_port.sv
/*
 * RAM write port: merges the engine requests and registers the frame RAM
 * address, data and write enable.
 */
`timescale 1ns/1ps

module ram_write_port (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  blank_req,
    input  matrix_pkg::ram_addr_t blank_addr,
    input  logic                  pixel_req,
    input  matrix_pkg::ram_addr_t pixel_addr,
    input  matrix_pkg::byte_t     pixel_data,
    output matrix_pkg::ram_addr_t ram_address,
    output matrix_pkg::byte_t     ram_data_out,
    output logic                  ram_write_enable
);

    // blank writes are always zero, so only pixel data reaches the RAM
    always_ff @(posedge clk_in) begin
        ram_address  <= (blank_req ? blank_addr : '0) | (pixel_req ? pixel_addr : '0);
        ram_data_out <= pixel_req ? pixel_data : '0;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
        end else begin
            ram_write_enable <= blank_req || pixel_req;
        end
    end

endmodule

//--- hdl/matrix_control_top.sv
/*
 * LED-matrix command front end: decodes serial command bytes into display
 * configuration and frame RAM writes.
 */
`timescale 1ns/1ps

module matrix_control_top (
    input  logic                    clk_in,
    input  logic                    reset,
    input  matrix_pkg::byte_t       data_rx,
    input  logic                    data_ready_n,
    output matrix_pkg::rgb_t        rgb_enable,
    output matrix_pkg::brightness_t brightness_enable,
    output matrix_pkg::ram_addr_t   ram_address,
    output matrix_pkg::byte_t       ram_data_out,
    output logic                    ram_write_enable,
    output logic                    busy,
    output logic                    ready_for_data
);

    matrix_pkg::byte_t     cmd_byte;
    logic                  cmd_byte_valid;
    logic                  brightness_load;
    logic                  blank_start;
    logic                  blank_done;
    logic                  blank_req;
    matrix_pkg::ram_addr_t blank_addr;
    logic                  pixel_byte_valid;
    logic                  pixel_done;
    logic                  pixel_req;
    matrix_pkg::ram_addr_t pixel_addr;
    matrix_pkg::byte_t     pixel_data;

    command_decoder u_decoder (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .data_ready_n     (data_ready_n),
        .blank_done       (blank_done),
        .pixel_done       (pixel_done),
        .cmd_byte         (cmd_byte),
        .cmd_byte_valid   (cmd_byte_valid),
        .brightness_load  (brightness_load),
        .blank_start      (blank_start),
        .pixel_byte_valid (pixel_byte_valid),
        .busy             (busy),
        .ready_for_data   (ready_for_data)
    );

    display_config_regs u_config_regs (
        .clk_in            (clk_in),
        .reset             (reset),
        .cmd_byte          (cmd_byte),
        .cmd_byte_valid    (cmd_byte_valid),
        .brightness_load   (brightness_load),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    // blank data is always zero and not routed
    blank_engine u_blank (
        .clk_in      (clk_in),
        .reset       (reset),
        .blank_start (blank_start),
        .wr_req      (blank_req),
        .wr_addr     (blank_addr),
        .wr_data     (),
        .blank_done  (blank_done)
    );

    pixel_write_engine u_pixel (
        .clk_in           (clk_in),
        .reset            (reset),
        .cmd_byte         (cmd_byte),
        .pixel_byte_valid (pixel_byte_valid),
        .wr_req           (pixel_req),
        .wr_addr          (pixel_addr),
        .wr_data          (pixel_data),
        .pixel_done       (pixel_done)
    );

    ram_write_port u_ram_port (
        .clk_in           (clk_in),
        .reset            (reset),
        .blank_req        (blank_req),
        .blank_addr       (blank_addr),
        .pixel_req        (pixel_req),
        .pixel_addr       (pixel_addr),
        .pixel_data       (pixel_data),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable)
    );

endmodule

//--- testbench/matrix_control_asserts.sv
/*
 * Bound checks on the matrix control top level for status levels and blank writes.
 */
`timescale 1ns/1ps

module matrix_control_asserts (
    input logic              clk_in,
    input logic              reset,
    input logic              busy,
    input logic              ready_for_data,
    input logic              ram_write_enable,
    input matrix_pkg::byte_t ram_data_out
);

    int assert_fail_count;

    initial assert_fail_count = 0;

    // host is stalled only while the blank sweep writes
    ready_needs_busy: assert property (
        @(posedge clk_in) disable iff (reset)
        !ready_for_data |-> (busy && (ram_write_enable || $fell(ready_for_data)))
    ) else begin
        $error("ready_for_data low while idle or without a blank write");
        assert_fail_count++;
    end

    blank_write_zero: assert property (
        @(posedge clk_in) disable iff (reset)
        (ram_write_enable && !ready_for_data) |-> (ram_data_out == '0)
    ) else begin
        $error("nonzero RAM write while blanking");
        assert_fail_count++;
    end

    reset_clears_status: assert property (
        @(posedge clk_in) reset |=> (!busy && !ram_write_enable)
    ) else begin
        $error("busy or ram_write_enable high after reset");
        assert_fail_count++;
    end

endmodule

bind matrix_control_top matrix_control_asserts u_asserts (.*);

//--- testbench/tb_matrix_control.sv
/*
 * Testbench for the LED-matrix command front end with random commands and
 * pixels, a reference model of the registers and frame RAM, and a write monitor.
 */
`timescale 1ns/1ps

module tb_matrix_control;

    localparam int NUM_RGB     = 20;
    localparam int NUM_BRIGHT  = 20;
    localparam int NUM_UNKNOWN = 8;
    localparam int NUM_PIXELS  = 4;
    localparam int RAM_WORDS   = 1 << matrix_pkg::RAM_ADDR_BITS;
    // worst case has every brightness command as T with its argument
    localparam int MAX_BYTES   = NUM_RGB + 2 * NUM_BRIGHT + NUM_UNKNOWN + 5 * (NUM_PIXELS + 1) + 1;
    localparam int WATCHDOG_CYCLES = 5 * RAM_WORDS + 40 * MAX_BYTES;

    logic                    clk_in = 1'b0;
    logic                    reset;
    matrix_pkg::byte_t       data_rx;
    logic                    data_ready_n;
    matrix_pkg::rgb_t        rgb_enable;
    matrix_pkg::brightness_t brightness_enable;
    matrix_pkg::ram_addr_t   ram_address;
    matrix_pkg::byte_t       ram_data_out;
    logic                    ram_write_enable;
    logic                    busy;
    logic                    ready_for_data;

    logic [15:0]             lfsr_state;
    string                   rgb_letters = "RrGgBb";
    matrix_pkg::rgb_t        exp_rgb;
    matrix_pkg::brightness_t exp_brightness;
    matrix_pkg::ram_addr_t   exp_addr_q[$];
    matrix_pkg::byte_t       exp_data_q[$];
    matrix_pkg::byte_t       model_mem [RAM_WORDS];
    matrix_pkg::byte_t       ref_mem [RAM_WORDS];
    int                      ready_low_count;

    always #50 clk_in = ~clk_in;

    matrix_control_top dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_address       (ram_address),
        .ram_data_out      (ram_data_out),
        .ram_write_enable  (ram_write_enable),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // galois form with taps 16 14 13 11
    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic matrix_pkg::rgb_t next_rgb(input matrix_pkg::rgb_t cur,
                                                  input matrix_pkg::byte_t c);
        matrix_pkg::rgb_t m;
        m = cur;
        case (c)
            "R": m[0] = 1'b1;
            "r": m[0] = 1'b0;
            "G": m[1] = 1'b1;
            "g": m[1] = 1'b0;
            "B": m[2] = 1'b1;
            "b": m[2] = 1'b0;
            default: ;
        endcase
        return m;
    endfunction

    function automatic matrix_pkg::brightness_t next_brightness(
            input matrix_pkg::brightness_t cur, input matrix_pkg::byte_t c);
        matrix_pkg::brightness_t m;
        int n;
        m = cur;
        n = int'(c) - int'(8'h30);
        if (c == "0") begin
            m = '0;
        end else if (c == "9") begin
            m = '1;
        end else if (n >= 1 && n <= matrix_pkg::BRIGHTNESS_LEVELS) begin
            m[matrix_pkg::BRIGHTNESS_LEVELS - n] = ~m[matrix_pkg::BRIGHTNESS_LEVELS - n];
        end
        return m;
    endfunction

    function automatic matrix_pkg::ram_addr_t pixel_address(input matrix_pkg::byte_t row_b,
            input matrix_pkg::byte_t col_b, input logic sel);
        return {row_b[4:0], col_b[5:0], sel};
    endfunction

    task automatic check_rgb(input matrix_pkg::rgb_t actual, input matrix_pkg::rgb_t expected);
        if (actual !== expected) begin
            $display("** Error: rgb_enable expected %h got %h", expected, actual);
            abort_run();
        end
    endtask

    task automatic check_brightness(input matrix_pkg::brightness_t actual,
                                    input matrix_pkg::brightness_t expected);
        if (actual !== expected) begin
            $display("** Error: brightness_enable expected %h got %h", expected, actual);
            abort_run();
        end
    endtask

    task automatic check_ram_write(input matrix_pkg::ram_addr_t addr, input matrix_pkg::byte_t data,
            input matrix_pkg::ram_addr_t exp_addr, input matrix_pkg::byte_t exp_data);
        if (addr !== exp_addr || data !== exp_data) begin
            $display("** Error: ram_address/ram_data_out expected %h/%h got %h/%h",
                     exp_addr, exp_data, addr, data);
            abort_run();
        end
    endtask

    task automatic check_ram_word(input matrix_pkg::ram_addr_t addr,
                                  input matrix_pkg::byte_t actual, input matrix_pkg::byte_t expected);
        if (actual !== expected) begin
            $display("** Error: frame RAM word %h expected %h got %h", addr, expected, actual);
            abort_run();
        end
    endtask

    task automatic send_byte(input matrix_pkg::byte_t value);
        while (ready_for_data !== 1'b1) @(posedge clk_in);
        data_rx      <= value;
        data_ready_n <= 1'b0;
        @(posedge clk_in);
        data_ready_n <= 1'b1;
        repeat (4) @(posedge clk_in);
    endtask

    task automatic send_command(input matrix_pkg::byte_t c);
        exp_rgb        = next_rgb(exp_rgb, c);
        exp_brightness = next_brightness(exp_brightness, c);
        send_byte(c);
        check_rgb(rgb_enable, exp_rgb);
        check_brightness(brightness_enable, exp_brightness);
    endtask

    task automatic run_brightness_commands(input int count);
        logic [7:0]        pick;
        matrix_pkg::byte_t arg;
        for (int i = 0; i < count; i++) begin
            pick = random_bits(4);
            if (pick >= 12) begin
                arg = random_bits(8);
                send_command("T");
                // argument byte loads the plane mask directly
                exp_brightness = arg[matrix_pkg::BRIGHTNESS_LEVELS-1:0];
                send_byte(arg);
                check_brightness(brightness_enable, exp_brightness);
            end else begin
                send_command((pick[2:0] == 3'd7) ? 8'h39 : (8'h30 + pick[2:0]));
            end
        end
    endtask

    task automatic write_pixel();
        matrix_pkg::byte_t     row_b, col_b, d_odd, d_even;
        matrix_pkg::ram_addr_t a_odd, a_even;
        row_b  = random_bits(8);
        col_b  = random_bits(8);
        d_odd  = random_bits(8);
        d_even = random_bits(8);
        a_odd  = pixel_address(row_b, col_b, 1'b1);
        a_even = pixel_address(row_b, col_b, 1'b0);
        exp_addr_q.push_back(a_odd);
        exp_data_q.push_back(d_odd);
        exp_addr_q.push_back(a_even);
        exp_data_q.push_back(d_even);
        ref_mem[a_odd]  = d_odd;
        ref_mem[a_even] = d_even;
        send_command("P");
        send_byte(row_b);
        send_byte(col_b);
        send_byte(d_odd);
        send_byte(d_even);
    endtask

    task automatic blank_panel();
        for (int a = 0; a < RAM_WORDS; a++) begin
            exp_addr_q.push_back(matrix_pkg::ram_addr_t'(a));
            exp_data_q.push_back('0);
            ref_mem[a] = '0;
        end
        ready_low_count = 0;
        send_command("Z");
        while (busy !== 1'b0) @(posedge clk_in);
        repeat (3) @(posedge clk_in);
        if (ready_low_count != RAM_WORDS) begin
            $display("** Error: ready_for_data low cycles expected %h got %h",
                     RAM_WORDS, ready_low_count);
            abort_run();
        end
    endtask

    task automatic compare_memory();
        for (int a = 0; a < RAM_WORDS; a++) begin
            check_ram_word(matrix_pkg::ram_addr_t'(a), model_mem[a], ref_mem[a]);
        end
    endtask

    // every observed write must match the next predicted one
    always @(posedge clk_in) begin
        if (!reset && ready_for_data === 1'b0) begin
            ready_low_count++;
        end
        if (!reset && ram_write_enable === 1'b1) begin
            if (exp_addr_q.size() == 0) begin
                $display("RAM write to address %h when no write was expected", ram_address);
                abort_run();
            end else begin
                check_ram_write(ram_address, ram_data_out,
                                exp_addr_q.pop_front(), exp_data_q.pop_front());
                model_mem[ram_address] = ram_data_out;
            end
        end
        if (dut.u_asserts.assert_fail_count != 0) begin
            $display("a bound assertion on the top level failed");
            abort_run();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        lfsr_state      = 16'd57857;
        reset           = 1'b1;
        data_rx         = '0;
        data_ready_n    = 1'b1;
        ready_low_count = 0;
        for (int a = 0; a < RAM_WORDS; a++) begin
            model_mem[a] = matrix_pkg::byte_t'(a ^ (a >> 4) ^ (a >> 8));
            ref_mem[a]   = matrix_pkg::byte_t'(a ^ (a >> 4) ^ (a >> 8));
        end
        repeat (10) @(posedge clk_in);
        reset <= 1'b0;
        @(posedge clk_in);
        exp_rgb        = '1;
        exp_brightness = '1;
        check_rgb(rgb_enable, exp_rgb);
        check_brightness(brightness_enable, exp_brightness);
        if (busy !== 1'b0 || ready_for_data !== 1'b1) begin
            $display("** Error: busy/ready_for_data expected 0/1 got %h/%h", busy, ready_for_data);
            abort_run();
        end
        for (int i = 0; i < NUM_RGB; i++) begin
            send_command(rgb_letters[random_bits(3) % 6]);
        end
        run_brightness_commands(NUM_BRIGHT);
        // bytes above 0x7f are never commands
        for (int i = 0; i < NUM_UNKNOWN; i++) begin
            send_command(random_bits(7) | 8'h80);
        end
        for (int i = 0; i < NUM_PIXELS; i++) begin
            write_pixel();
        end
        compare_memory();
        blank_panel();
        write_pixel();
        compare_memory();
        if (exp_addr_q.size() != 0) begin
            $display("%0d expected RAM writes never happened", exp_addr_q.size());
            abort_run();
        end
        if (dut.u_asserts.assert_fail_count != 0) begin
            $display("%0d assertion failures", dut.u_asserts.assert_fail_count);
            abort_run();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- compile.f
hdl/matrix_pkg.sv
hdl/command_decoder.sv
hdl/display_config_regs.sv
hdl/blank_engine.sv
hdl/pixel_write_engine.sv
hdl/ram_write_port.sv
hdl/matrix_control_top.sv
testbench/matrix_control_asserts.sv
testbench/tb_matrix_control.sv
